//--- design/cameraInit_config.svh
`ifndef CAMERA_INIT_CONFIG_SVH
`define CAMERA_INIT_CONFIG_SVH

// System clocks per quarter of an SCL period
// Four quarters give one bit slot on the bus
`define SCCB_QUARTER_CYCLES 4

// SCCB device address of the OV5640 with the write bit clear
`define SENSOR_WRITE_ADDR 8'h78

// Settle time after the software reset entry
// Short value for simulation, the sensor needs about 5 ms on hardware
`define RESET_DELAY_CYCLES 200

`endif

//--- design/camRegPkg.sv
`default_nettype none

package camRegPkg;

	// Sensor register map types shared by table and sequencer

	typedef logic [15:0] regAddr_t;  // OV5640 register address
	typedef logic [7:0]  regData_t;  // Register value
	typedef logic [9:0]  tableIndex_t;  // Table position, 1024 entries max

	// One table entry, address in the upper 16 bits
	typedef struct packed
	{
		regAddr_t addr;  // Target register
		regData_t data;  // Value to write
	} regEntry_t;

endpackage

`default_nettype wire

//--- design/sccbPkg.sv
`default_nettype none

package sccbPkg;

	import camRegPkg::*;

	// Write request from sequencer to writer
	typedef struct packed
	{
		regEntry_t entry;  // Address and value of one write
	} sccbWrite_t;

	// Frame level states of the writer
	typedef enum logic [1:0]
	{
		writerIdle,  // Bus released
		writerStart,  // Start condition
		writerShift,  // 36 bit slots
		writerStop  // Stop condition
	} writerState_t;

	typedef logic [5:0]  bitCount_t;  // Slot counter 0..35
	typedef logic [1:0]  sclPhase_t;  // Quarter within a slot
	typedef logic [15:0] quarterCount_t;  // Clock divider count
	typedef logic [31:0] frameBits_t;  // Device, addr high, addr low, data

endpackage

`default_nettype wire

//--- design/ov5640RegTable.sv
`timescale 1ns/1ps
`default_nettype none

module ov5640RegTable
	import camRegPkg::*;
(
	input wire tableIndex_t index,
	output regEntry_t entry,
	output tableIndex_t tableSize
);

localparam tableIndex_t EntryCount = 10'd40;  // Entries below

assign tableSize = EntryCount;

// Sensor bring-up order
// Address in bits 23:8 and value in bits 7:0
always_comb
begin
	case (index)
		0:       entry = 24'h310311;  // System clock from pad
		1:       entry = 24'h300882;  // Software reset by bit 7
		2:       entry = 24'h300842;  // Software power down by bit 6
		3:       entry = 24'h310303;  // System clock from PLL
		4:       entry = 24'h3017ff;  // FREX VSYNC HREF PCLK and D[9:6] enable
		5:       entry = 24'h3018ff;  // D[5:0] and GPIO enable
		6:       entry = 24'h30341a;  // 10-bit mode
		7:       entry = 24'h303713;  // PLL root and pre-divider
		8:       entry = 24'h310801;  // PCLK and SCLK root dividers
		9:       entry = 24'h303541;  // PLL system divider
		10:      entry = 24'h303669;  // PLL multiplier
		11:      entry = 24'h300000;  // Enable blocks
		12:      entry = 24'h3004ff;  // Enable clocks
		13:      entry = 24'h300e58;  // MIPI off and DVP on
		14:      entry = 24'h430030;  // YUV422 YUYV output
		15:      entry = 24'h501f00;  // ISP format select
		16:      entry = 24'h380000;  // Window X start high
		17:      entry = 24'h380100;  // Window X start low
		18:      entry = 24'h380200;  // Window Y start high
		19:      entry = 24'h3803fa;  // Window Y start low
		20:      entry = 24'h38040a;  // Window X end high
		21:      entry = 24'h38053f;  // Window X end low
		22:      entry = 24'h380606;  // Window Y end high
		23:      entry = 24'h3807a9;  // Window Y end low
		24:      entry = 24'h380805;  // Output width high for 1280
		25:      entry = 24'h380900;  // Output width low
		26:      entry = 24'h380a02;  // Output height high for 720
		27:      entry = 24'h380bd0;  // Output height low
		28:      entry = 24'h53811e;  // CMX1 for Y
		29:      entry = 24'h53825b;  // CMX2 for Y
		30:      entry = 24'h538308;  // CMX3 for Y
		31:      entry = 24'h53840a;  // CMX4 for U
		32:      entry = 24'h53857e;  // CMX5 for U
		33:      entry = 24'h538688;  // CMX6 for U
		34:      entry = 24'h3a0f30;  // AEC stable range inner high
		35:      entry = 24'h3a1028;  // AEC stable range inner low
		36:      entry = 24'h5180ff;  // AWB B block
		37:      entry = 24'h300802;  // Wake from standby
		38:      entry = 24'h3b0083;  // Strobe request on in LED3 mode
		39:      entry = 24'h3b0000;  // Strobe request off
		default: entry = 24'h000000;  // Past the end
	endcase
end

endmodule

`default_nettype wire

//--- design/sccbWriter.sv
`timescale 1ns/1ps
`default_nettype none

`include "cameraInit_config.svh"

module sccbWriter
	import sccbPkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic writeStart,
	input wire sccbWrite_t request,
	output logic sioc,
	output logic siodOe,
	input wire logic siodIn,
	output logic busy,
	output logic writeDone,
	output logic ackMissing
);

localparam quarterCount_t QuarterLast = quarterCount_t'(`SCCB_QUARTER_CYCLES - 1);
localparam bitCount_t LastSlot = 6'd35;  // Four bytes of nine slots

writerState_t state;
sclPhase_t phase;  // Quarter within the current slot
quarterCount_t quarterCount;
bitCount_t bitCount;  // Slot in the frame
logic [3:0] slotInByte;  // 8 is the acknowledge slot
frameBits_t frame;  // MSB goes out next
logic siodMeta;
logic siodSync;
logic quarterTick;
logic ackSlot;

assign quarterTick = (quarterCount == QuarterLast);
assign ackSlot = (slotInByte == 4'd8);

// SIOD comes from the pad, two flops before use
always_ff @(posedge clk)
begin
	siodMeta <= siodIn;
	siodSync <= siodMeta;
end

// Frame register loads on start and shifts once per data slot
always_ff @(posedge clk)
begin
	if (state == writerIdle && writeStart)
		frame <= {`SENSOR_WRITE_ADDR, request.entry.addr, request.entry.data};
	else if (state == writerShift && quarterTick && phase == 2'd0 && !ackSlot)
		frame <= frame << 1;
end

always_ff @(posedge clk)
begin
	if (reset)
	begin
		state <= writerIdle;
		phase <= '0;
		quarterCount <= '0;
		bitCount <= '0;
		slotInByte <= '0;
		sioc <= 1'b1;  // Bus idles high
		siodOe <= 1'b0;
		busy <= 1'b0;
		writeDone <= 1'b0;
		ackMissing <= 1'b0;
	end
	else
	begin
		writeDone <= 1'b0;  // Single cycle pulse
		if (state != writerIdle)
		begin
			quarterCount <= quarterTick ? '0 : quarterCount + 1'b1;
			if (quarterTick)
				phase <= phase + 1'b1;  // Wraps to 0 each slot
		end
		case (state)
			writerIdle:
			begin
				if (writeStart)
				begin
					state <= writerStart;
					busy <= 1'b1;
					ackMissing <= 1'b0;  // New frame, fresh result
				end
			end
			writerStart:
			begin
				if (quarterTick)
				begin
					case (phase)
						2'd0: siodOe <= 1'b1;  // SIOD falls with SCL high
						2'd2: sioc <= 1'b0;
						2'd3:
						begin
							state <= writerShift;
							bitCount <= '0;
							slotInByte <= '0;
						end
						default: ;
					endcase
				end
			end
			writerShift:
			begin
				if (quarterTick)
				begin
					case (phase)
						2'd0: siodOe <= ackSlot ? 1'b0 : ~frame[31];  // SCL low here
						2'd1: sioc <= 1'b1;
						2'd2:
						begin
							if (ackSlot && siodSync)
								ackMissing <= 1'b1;  // No pull-down from sensor
						end
						2'd3:
						begin
							sioc <= 1'b0;
							if (bitCount == LastSlot)
								state <= writerStop;
							else
							begin
								bitCount <= bitCount + 1'b1;
								slotInByte <= ackSlot ? 4'd0 : slotInByte + 1'b1;
							end
						end
						default: ;
					endcase
				end
			end
			writerStop:
			begin
				if (quarterTick)
				begin
					case (phase)
						2'd0: siodOe <= 1'b1;  // Pull low before SCL rises
						2'd1: sioc <= 1'b1;
						2'd2: siodOe <= 1'b0;  // SIOD rises with SCL high
						2'd3:
						begin
							state <= writerIdle;
							busy <= 1'b0;
							writeDone <= 1'b1;
						end
						default: ;
					endcase
				end
			end
			default: state <= writerIdle;
		endcase
	end
end

endmodule

`default_nettype wire

//--- design/cameraInitSequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "cameraInit_config.svh"

module cameraInitSequencer
	import camRegPkg::*;
	import sccbPkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic configStart,
	input wire regEntry_t entry,
	input wire tableIndex_t tableSize,
	output tableIndex_t index,
	output sccbWrite_t request,
	output logic writeStart,
	input wire logic busy,
	input wire logic writeDone,
	input wire logic ackMissing,
	output logic configDone,
	output logic configError
);

typedef enum logic [2:0]
{
	seqIdle,  // Waiting for first start
	seqIssue,  // Start pulse when writer is free
	seqWaitWrite,  // Frame on the bus
	seqResetDelay,  // Sensor settling after soft reset
	seqDone  // Table finished
} seqState_t;

localparam regAddr_t SysCtrlAddr = 16'h3008;  // System control 00
localparam logic [15:0] DelayLast = 16'(`RESET_DELAY_CYCLES - 1);

seqState_t state;
logic [15:0] delayCount;
logic isSoftReset;
tableIndex_t lastIndex;

// Index only moves after writeDone so the request stays put during a frame
assign request = '{entry: entry};
assign writeStart = (state == seqIssue) && !busy;
assign lastIndex = tableSize - 1'b1;

// Bit 7 of 0x3008 resets the whole sensor
assign isSoftReset = (request.entry.addr == SysCtrlAddr) && request.entry.data[7];

always_ff @(posedge clk)
begin
	if (reset)
	begin
		state <= seqIdle;
		index <= '0;
		delayCount <= '0;
		configDone <= 1'b0;
		configError <= 1'b0;
	end
	else
	begin
		case (state)
			seqIdle, seqDone:
			begin
				if (configStart)
				begin
					state <= seqIssue;
					index <= '0;  // Always from the top
					configDone <= 1'b0;
					configError <= 1'b0;
				end
			end
			seqIssue:
			begin
				if (writeStart)
					state <= seqWaitWrite;
			end
			seqWaitWrite:
			begin
				if (writeDone)
				begin
					if (ackMissing)
						configError <= 1'b1;  // Sticky, sequence goes on
					if (index == lastIndex)
					begin
						state <= seqDone;
						configDone <= 1'b1;
					end
					else
					begin
						index <= index + 1'b1;
						if (isSoftReset)
						begin
							delayCount <= DelayLast;
							state <= seqResetDelay;
						end
						else
							state <= seqIssue;  // Back to back
					end
				end
			end
			seqResetDelay:
			begin
				if (delayCount == '0)
					state <= seqIssue;
				else
					delayCount <= delayCount - 1'b1;
			end
			default: state <= seqIdle;
		endcase
	end
end

endmodule

`default_nettype wire

//--- design/cameraInitTop.sv
`timescale 1ns/1ps
`default_nettype none

module cameraInitTop
	import camRegPkg::*;
	import sccbPkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic configStart,
	output logic sioc,
	output logic siodOe,
	input wire logic siodIn,
	output logic configDone,
	output logic configError
);

tableIndex_t index;
tableIndex_t tableSize;
regEntry_t entry;
sccbWrite_t request;  // Held by sequencer for the whole frame
logic writeStart;
logic busy;
logic writeDone;
logic ackMissing;  // Valid with writeDone

ov5640RegTable regTable_i
(
	.index(index),
	.entry(entry),
	.tableSize(tableSize)
);

cameraInitSequencer sequencer_i
(
	.clk(clk),
	.reset(reset),
	.configStart(configStart),
	.entry(entry),
	.tableSize(tableSize),
	.index(index),
	.request(request),
	.writeStart(writeStart),
	.busy(busy),
	.writeDone(writeDone),
	.ackMissing(ackMissing),
	.configDone(configDone),
	.configError(configError)
);

sccbWriter writer_i
(
	.clk(clk),
	.reset(reset),
	.writeStart(writeStart),
	.request(request),
	.sioc(sioc),
	.siodOe(siodOe),  // Open drain, high pulls SIOD low
	.siodIn(siodIn),
	.busy(busy),
	.writeDone(writeDone),
	.ackMissing(ackMissing)
);

endmodule

`default_nettype wire

//--- tb/sccbTargetModel.sv
`timescale 1ns/1ps
`default_nettype none

`include "cameraInit_config.svh"

module sccbTargetModel
	import camRegPkg::*;
(
	input wire logic sioc,
	input wire logic siod,  // Resolved open-drain line
	input wire logic withholdAck,  // Skip the data ack for one register
	input wire regAddr_t withheldReg,
	output logic pullDown  // High pulls SIOD low
);

logic [31:0] shiftReg;  // Device, addr high, addr low, data
int slot;  // Bit slots seen in this frame
logic inFrame;
time frameStart;

// Write log, read by the testbench after each run
int writeCount;
logic [7:0] deviceLog [0:255];
regEntry_t entryLog [0:255];
time startLog [0:255];  // Start condition
time endLog [0:255];  // Stop condition

function automatic logic ackThisByte();
	if (slot == 8)
		return shiftReg[7:0] == `SENSOR_WRITE_ADDR;  // Only answer to our own address
	if (slot == 35 && withholdAck && shiftReg[23:8] == withheldReg)
		return 1'b0;
	return 1'b1;
endfunction

initial
begin
	pullDown = 1'b0;
	inFrame = 1'b0;
	slot = 0;
	writeCount = 0;
	shiftReg = '0;
	frameStart = 0;
end

always @(negedge siod)
begin
	if (sioc)
	begin
		inFrame = 1'b1;  // Start, SIOD falls with SCL high
		slot = 0;
		shiftReg = '0;
		frameStart = $time;
	end
end

always @(posedge siod)
begin
	if (sioc && inFrame)
	begin
		inFrame = 1'b0;  // Stop condition
		if (slot == 36 && writeCount < 256)
		begin
			deviceLog[writeCount] = shiftReg[31:24];
			entryLog[writeCount] = shiftReg[23:0];
			startLog[writeCount] = frameStart;
			endLog[writeCount] = $time;
			writeCount++;
		end
	end
end

// Data sampled on rising SCL, every ninth slot is the ack
always @(posedge sioc)
begin
	if (inFrame && slot < 36)
	begin
		if (slot % 9 != 8)
			shiftReg = {shiftReg[30:0], siod};
		slot++;
	end
end

// Ack held from one falling SCL edge to the next
always @(negedge sioc)
begin
	if (inFrame)
		pullDown <= (slot % 9 == 8) && ackThisByte();
end

endmodule

`default_nettype wire

//--- tb/cameraInit_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module cameraInit_asserts
	import sccbPkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic configStart,
	input wire logic sioc,
	input wire logic siodOe,
	input wire logic configDone,
	input wire logic configError,
	input wire writerState_t writerState
);

int failCount = 0;  // Failed assertions so far

// Bus idle and status low right after reset
resetValues: assert property (@(posedge clk)
	reset |=> (sioc && !siodOe && !configDone && !configError))
else
begin
	$error("Bus or status pins not idle after reset");
	failCount++;
end

// SIOD moves under high SCL only for start and stop
siodStable: assert property (@(posedge clk) disable iff (reset)
	(sioc && $past(sioc) && siodOe != $past(siodOe))
	|-> (writerState == writerStart || writerState == writerStop))
else
begin
	$error("SIOD changed while SCL was high inside a frame");
	failCount++;
end

errorSticky: assert property (@(posedge clk) disable iff (reset)
	$fell(configError) |-> $past(configStart))
else
begin
	$error("configError fell without configStart");
	failCount++;
end

doneHeld: assert property (@(posedge clk) disable iff (reset)
	$fell(configDone) |-> $past(configStart))
else
begin
	$error("configDone fell without configStart");
	failCount++;
end

endmodule

bind cameraInitTop cameraInit_asserts asserts_i
(
	.clk(clk),
	.reset(reset),
	.configStart(configStart),
	.sioc(sioc),
	.siodOe(siodOe),
	.configDone(configDone),
	.configError(configError),
	.writerState(writer_i.state)  // Frame phase that tells start and stop apart
);

`default_nettype wire

//--- tb/cameraInitTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cameraInit_config.svh"

module cameraInitTb
	import camRegPkg::*;
();

localparam int ClockPeriod = 40;
localparam int TimeoutCycles = 40000;  // Well above one full table
localparam int TableLength = 40;

logic clk;
logic reset;
logic configStart;
logic withholdAck;
regAddr_t withheldReg;
logic sioc;
logic siodOe;
logic pullDown;
wire logic siod;
logic configDone;
logic configError;
int testErrors;
int totalErrors;
int testsRun;
int testsFailed;
int firstWrite;  // Log position of the current run
logic timedOut;
time doneTime;

assign siod = !(siodOe || pullDown);  // Wired AND with the pull-up giving the high

cameraInitTop dut_i
(
	.clk(clk),
	.reset(reset),
	.configStart(configStart),
	.sioc(sioc),
	.siodOe(siodOe),
	.siodIn(siod),
	.configDone(configDone),
	.configError(configError)
);

sccbTargetModel model_i
(
	.sioc(sioc),
	.siod(siod),
	.withholdAck(withholdAck),
	.withheldReg(withheldReg),
	.pullDown(pullDown)
);

initial
begin
	clk = 1'b0;
	forever #(ClockPeriod / 2) clk = ~clk;
end

task automatic nextCycle();
	@(posedge clk);
	#2;  // Drive and sample clear of the edge
endtask

task automatic checkValue(input string name, input logic [31:0] actual,
	input logic [31:0] expected);
	assert (actual === expected)
	else
	begin
		$display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
		testErrors++;
	end
endtask

task automatic checkTrue(input string message, input logic cond);
	assert (cond)
	else
	begin
		$display("Failure at %0t ns: %s", $time, message);
		testErrors++;
	end
endtask

task automatic finishTest(input string name);
	testsRun++;
	if (testErrors != 0)
		testsFailed++;
	$display("Test %0d %s: %s, %0d errors", testsRun, name,
		testErrors != 0 ? "failed" : (timedOut ? "skipped" : "passed"), testErrors);
	totalErrors += testErrors;
	testErrors = 0;
endtask

task automatic pulseStart();
	configStart = 1'b1;
	nextCycle();
	configStart = 1'b0;
endtask

task automatic waitDone();
	int n;
	n = 0;
	while (!configDone && n < TimeoutCycles)
	begin
		nextCycle();
		n++;
	end
	doneTime = $time;
	if (!configDone)
	begin
		$display("Timeout at %0t ns: configDone never rose", $time);
		timedOut = 1'b1;
		testErrors++;
	end
endtask

task automatic waitWrites(input int count);
	int n;
	n = 0;
	while (model_i.writeCount - firstWrite < count && n < TimeoutCycles)
	begin
		nextCycle();
		n++;
	end
	if (model_i.writeCount - firstWrite < count)
	begin
		$display("Timeout at %0t ns: only %0d writes seen", $time,
			model_i.writeCount - firstWrite);
		timedOut = 1'b1;
		testErrors++;
	end
endtask

task automatic runTable();
	firstWrite = model_i.writeCount;
	pulseStart();
	waitDone();
endtask

// Count, device byte and done after the last stop
task automatic checkRunLog();
	int count;
	count = model_i.writeCount - firstWrite;
	checkValue("write count", count, TableLength);
	for (int i = 0; i < count && i < TableLength; i++)
		checkValue("device address", model_i.deviceLog[firstWrite + i], `SENSOR_WRITE_ADDR);
	if (count > 0)
		checkTrue("configDone rose before the last write ended",
			doneTime > model_i.endLog[firstWrite + count - 1]);
endtask

task automatic checkResetGap();
	time gap;
	regEntry_t written;
	logic found;
	found = 1'b0;
	for (int i = firstWrite; i < firstWrite + TableLength - 1; i++)
	begin
		written = model_i.entryLog[i];
		gap = (model_i.startLog[i + 1] - model_i.endLog[i]) / ClockPeriod;  // In clocks
		if (written.addr == 16'h3008 && written.data[7])
		begin
			found = 1'b1;
			checkTrue("gap after the software reset is too short", gap >= `RESET_DELAY_CYCLES);
		end
		else
			checkTrue("gap between ordinary writes reaches the reset delay",
				gap < `RESET_DELAY_CYCLES);
	end
	checkTrue("no software reset write in the log", found);
endtask

initial
begin
	configStart = 1'b0;
	reset = 1'b1;
	withholdAck = 1'b0;
	withheldReg = '0;
	testErrors = 0;
	totalErrors = 0;
	testsRun = 0;
	testsFailed = 0;
	firstWrite = 0;
	timedOut = 1'b0;
	doneTime = 0;
	repeat (8) nextCycle();
	reset = 1'b0;
	nextCycle();

	checkValue("sioc", sioc, 1'b1);
	checkValue("siod", siod, 1'b1);
	checkValue("siodOe", siodOe, 1'b0);
	checkValue("configDone", configDone, 1'b0);
	checkValue("configError", configError, 1'b0);
	finishTest("reset state");

	runTable();
	if (!timedOut)
	begin
		checkRunLog();
		checkValue("entry 0", model_i.entryLog[firstWrite], 24'h310311);
		checkValue("entry 1", model_i.entryLog[firstWrite + 1], 24'h300882);
		checkValue("entry 39", model_i.entryLog[firstWrite + 39], 24'h3b0000);
		checkValue("configError", configError, 1'b0);
	end
	finishTest("write order");

	if (!timedOut)
		checkResetGap();
	finishTest("reset delay");

	withholdAck = 1'b1;  // Sensor stays silent on 0x3017 data
	withheldReg = 16'h3017;
	if (!timedOut)
		runTable();
	if (!timedOut)
	begin
		checkRunLog();
		checkValue("configError", configError, 1'b1);
	end
	withholdAck = 1'b0;
	finishTest("missing acknowledge");

	if (!timedOut)
	begin
		firstWrite = model_i.writeCount;
		pulseStart();  // Restart after done
		checkValue("configDone", configDone, 1'b0);
		checkValue("configError", configError, 1'b0);
		waitWrites(5);
		if (!timedOut)
		begin
			pulseStart();  // Mid sequence start that the DUT ignores
			waitDone();
		end
		if (!timedOut)
		begin
			checkRunLog();
			checkValue("configError", configError, 1'b0);
		end
	end
	finishTest("start handling");

	$display("Summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
		testsRun, testsFailed, totalErrors, dut_i.asserts_i.failCount);
	if (testsFailed == 0 && dut_i.asserts_i.failCount == 0)
		$display("ALL CHECKS PASSED");
	else
		$display("CHECKS FAILED");
	$finish;
end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+design
design/camRegPkg.sv
design/sccbPkg.sv
design/ov5640RegTable.sv
design/sccbWriter.sv
design/cameraInitSequencer.sv
design/cameraInitTop.sv
tb/sccbTargetModel.sv
tb/cameraInit_asserts.sv
tb/cameraInitTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module cameraInitTb
out=$(./obj_dir/VcameraInitTb +verilator+error+limit+1000) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED"
